//--- verilog/uart_emu_config.svh
// Build-time sizes for the UART emulation front end, included by the package, queue and bench
`ifndef UART_EMU_CONFIG_SVH
`define UART_EMU_CONFIG_SVH

// log2 of the character queue depth (3 gives 8 entries)
`define UART_FIFO_AW 3

// Register address width of the 16550 map
`define UART_ADDR_W 3

`endif

//--- verilog/uart_emu_pkg.sv
// Shared types for the UART emulation front end, referenced by scoped name from RTL and bench
`default_nettype none

`include "uart_emu_config.svh"

package uart_emu_pkg;

   // 16550 register offsets, DLAB remaps 0 and 1 onto the divisor latch
   typedef enum logic [`UART_ADDR_W-1:0] {
      RBR_THR = 0,
      IER     = 1,
      IIR_FCR = 2,
      LCR     = 3,
      LSR     = 5
   } reg_addr_e;

   // Interrupt identification codes in IIR[3:0]
   typedef enum logic [3:0] {
      NONE = 4'b0001,
      LS   = 4'b0110,
      RBF  = 4'b0100,
      TBE  = 4'b0010
   } intr_id_e;

   // Transmit drain states
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      GAP   = 2'd1,
      OFFER = 2'd2
   } tx_state_e;

endpackage

`default_nettype wire

//--- verilog/uart_ctrl_if.sv
// Control path between the register block and the transmit side of the UART emulation
`default_nettype none

interface uart_ctrl_if;

   // Divisor latch value, sets the minimum gap between characters
   logic [15:0] divisor;

   // One-cycle queue clear pulses from FCR writes
   logic        rx_clear;
   logic        tx_clear;

   // Transmit state machine has nothing in flight
   logic        tx_idle;

   modport regs (output divisor, output rx_clear, output tx_clear, input tx_idle);
   modport tx (input divisor, input tx_clear, output tx_idle);

endinterface

`default_nettype wire

//--- verilog/char_fifo.sv
// Show-ahead byte queue with synchronous clear, one each for receive and transmit
`default_nettype none

`include "uart_emu_config.svh"

module char_fifo (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       clear,
   input  wire logic       push,
   input  wire logic [7:0] wdata,
   output logic            full,
   input  wire logic       pop,
   output logic [7:0]      rdata,
   output logic            empty
);

   localparam int DEPTH = 1 << `UART_FIFO_AW;
   localparam logic [`UART_FIFO_AW:0] FULL_COUNT = (`UART_FIFO_AW + 1)'(DEPTH);

   logic [7:0]               mem [DEPTH];
   logic [`UART_FIFO_AW-1:0] wr_ptr;
   logic [`UART_FIFO_AW-1:0] rd_ptr;
   logic [`UART_FIFO_AW:0]   count;

   logic do_push;
   logic do_pop;

   assign full  = (count == FULL_COUNT);
   assign empty = (count == '0);

   // Out-of-range requests are dropped silently
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign rdata = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/tx_pace_timer.sv
// Gap timer for the transmit side, loaded on start and pulsing done when it runs out
`default_nettype none

module tx_pace_timer (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        start,
   input  wire logic [15:0] divisor,
   output logic             done
);

   logic [15:0] count;
   logic [15:0] load;

   // A zero divisor still gives a one-cycle gap
   assign load = (divisor == 16'd0) ? 16'd1 : divisor;

   // The divisor is sampled only at start so a change applies to the next character
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= 16'd0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            count <= load;
         end else if (count != 16'd0) begin
            count <= count - 16'd1;
            if (count == 16'd1) begin
               done <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/tx_drain_fsm.sv
// Drains the transmit queue onto the valid/ready output, pacing or dropping characters
`default_nettype none

module tx_drain_fsm (
   input  wire logic       clk,
   input  wire logic       rst,

   uart_ctrl_if.tx         ctrl,

   input  wire logic       tx_empty,
   input  wire logic [7:0] tx_head,
   output logic            tx_pop,

   output logic            timer_start,
   input  wire logic       timer_done,

   input  wire logic       drop,
   output logic            out_valid,
   output logic [7:0]      out_char,
   input  wire logic       out_ready
);

   uart_emu_pkg::tx_state_e state;
   uart_emu_pkg::tx_state_e state_nxt;

   assign ctrl.tx_idle = (state == uart_emu_pkg::IDLE);

   // Head stays put while offered since only this block pops
   assign out_valid = (state == uart_emu_pkg::OFFER);
   assign out_char  = tx_head;

   always_comb begin
      state_nxt   = state;
      tx_pop      = 1'b0;
      timer_start = 1'b0;

      case (state)
         uart_emu_pkg::IDLE: begin
            if (!tx_empty && !ctrl.tx_clear) begin
               timer_start = 1'b1;
               state_nxt   = uart_emu_pkg::GAP;
            end
         end
         uart_emu_pkg::GAP: begin
            // Drop is decided here so a raised out_valid is never withdrawn
            if (timer_done) begin
               if (drop) begin
                  tx_pop    = 1'b1;
                  state_nxt = uart_emu_pkg::IDLE;
               end else begin
                  state_nxt = uart_emu_pkg::OFFER;
               end
            end
         end
         uart_emu_pkg::OFFER: begin
            if (out_ready) begin
               tx_pop    = 1'b1;
               state_nxt = uart_emu_pkg::IDLE;
            end
         end
         default: state_nxt = uart_emu_pkg::IDLE;
      endcase

      if (ctrl.tx_clear) begin
         state_nxt = uart_emu_pkg::IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= uart_emu_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

`default_nettype wire

//--- verilog/uart_emu_regs.sv
// 16550 register map on a req/ack bus, pushing and popping the character queues
`default_nettype none

`include "uart_emu_config.svh"

module uart_emu_regs (
   input  wire logic                    clk,
   input  wire logic                    rst,

   input  wire logic                    req,
   input  wire logic [`UART_ADDR_W-1:0] addr,
   input  wire logic                    write,
   input  wire logic [7:0]              wdata,
   output logic                         ack,
   output logic [7:0]                   rdata,

   uart_ctrl_if.regs                    ctrl,

   input  wire logic                    rx_empty,
   input  wire logic [7:0]              rx_head,
   output logic                         rx_pop,

   input  wire logic                    tx_full,
   input  wire logic                    tx_empty,
   output logic                         tx_push,
   output logic [7:0]                   tx_data,

   output logic                         irq
);

   // Sampled bus request
   logic                    req_q;
   uart_emu_pkg::reg_addr_e addr_q;
   logic                    write_q;

   logic [7:0]  lcr;
   logic [15:0] divisor_latch;
   logic        erbfi;
   logic        etbei;
   logic        elsi;
   logic        fifo_enable;

   // Register write strobes qualified by ack
   logic lcr_we;
   logic ier_we;
   logic fcr_we;
   logic dll_we;
   logic dlm_we;

   logic                   dlab;
   logic                   irq_rbf;
   logic                   irq_tbe;
   uart_emu_pkg::intr_id_e iir_code;
   logic [7:0]             lsr;

   assign dlab = lcr[7];

   assign irq_rbf = erbfi & ~rx_empty;
   assign irq_tbe = etbei & tx_empty;
   assign irq     = irq_rbf | irq_tbe;

   // Receive data ahead of transmit empty; line status never fires here
   always_comb begin
      if (irq_rbf) begin
         iir_code = uart_emu_pkg::RBF;
      end else if (irq_tbe) begin
         iir_code = uart_emu_pkg::TBE;
      end else begin
         iir_code = uart_emu_pkg::NONE;
      end
   end

   // TEMT needs the drain state machine idle as well
   assign lsr = {1'b0, tx_empty & ctrl.tx_idle, tx_empty, 4'b0000, ~rx_empty};

   assign tx_data       = wdata;
   assign ctrl.divisor  = divisor_latch;
   assign ctrl.rx_clear = fcr_we & wdata[0] & wdata[1];
   assign ctrl.tx_clear = fcr_we & wdata[0] & wdata[2];

   // Decode; the live req keeps the ack to a single cycle per access
   always_comb begin
      ack     = 1'b0;
      rdata   = 8'h00;
      rx_pop  = 1'b0;
      tx_push = 1'b0;
      lcr_we  = 1'b0;
      ier_we  = 1'b0;
      fcr_we  = 1'b0;
      dll_we  = 1'b0;
      dlm_we  = 1'b0;

      if (req_q && req) begin
         case (addr_q)
            uart_emu_pkg::RBR_THR: begin
               if (dlab) begin
                  ack    = 1'b1;
                  dll_we = write_q;
                  rdata  = divisor_latch[7:0];
               end else if (write_q) begin
                  // Hold the bus off until the transmit queue has room
                  ack     = ~tx_full;
                  tx_push = ~tx_full;
               end else begin
                  ack    = ~rx_empty;
                  rx_pop = ~rx_empty;
                  rdata  = rx_head;
               end
            end
            uart_emu_pkg::IER: begin
               ack = 1'b1;
               if (dlab) begin
                  dlm_we = write_q;
                  rdata  = divisor_latch[15:8];
               end else begin
                  ier_we = write_q;
                  rdata  = {5'b00000, elsi, etbei, erbfi};
               end
            end
            uart_emu_pkg::IIR_FCR: begin
               ack    = 1'b1;
               fcr_we = write_q;
               rdata  = {fifo_enable, fifo_enable, 2'b00, iir_code};
            end
            uart_emu_pkg::LCR: begin
               ack    = 1'b1;
               lcr_we = write_q;
               rdata  = lcr;
            end
            uart_emu_pkg::LSR: begin
               ack   = 1'b1;
               rdata = lsr;
            end
            default: begin
               // Unimplemented offsets still answer so the host never hangs
               ack = 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         req_q         <= 1'b0;
         addr_q        <= uart_emu_pkg::RBR_THR;
         write_q       <= 1'b0;
         lcr           <= 8'h00;
         divisor_latch <= 16'h0000;
         erbfi         <= 1'b0;
         etbei         <= 1'b0;
         elsi          <= 1'b0;
         fifo_enable   <= 1'b0;
      end else begin
         req_q   <= req;
         addr_q  <= uart_emu_pkg::reg_addr_e'(addr);
         write_q <= write;
         if (lcr_we) begin
            lcr <= wdata;
         end
         if (dll_we) begin
            divisor_latch[7:0] <= wdata;
         end
         if (dlm_we) begin
            divisor_latch[15:8] <= wdata;
         end
         if (ier_we) begin
            {elsi, etbei, erbfi} <= wdata[2:0];
         end
         if (fcr_we) begin
            fifo_enable <= wdata[0];
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/uart_emu_top.sv
// Top of the 16550 emulation, wiring the register block, queues, pacing timer and drain FSM
`default_nettype none

`include "uart_emu_config.svh"

module uart_emu_top (
   input  wire logic                    clk,
   input  wire logic                    rst,

   input  wire logic                    req,
   input  wire logic [`UART_ADDR_W-1:0] addr,
   input  wire logic                    write,
   input  wire logic [7:0]              wdata,
   output logic                         ack,
   output logic [7:0]                   rdata,

   input  wire logic                    drop,

   output logic                         out_valid,
   output logic [7:0]                   out_char,
   input  wire logic                    out_ready,

   input  wire logic                    in_valid,
   input  wire logic [7:0]              in_char,
   output logic                         in_ready,

   output logic                         irq
);

   uart_ctrl_if ctrl_if ();

   logic       rx_full;
   logic       rx_empty;
   logic       rx_pop;
   logic [7:0] rx_head;

   logic       tx_full;
   logic       tx_empty;
   logic       tx_push;
   logic       tx_pop;
   logic [7:0] tx_data;
   logic [7:0] tx_head;

   logic timer_start;
   logic timer_done;

   // The queue ignores pushes when full, so in_valid feeds it directly
   assign in_ready = ~rx_full;

   uart_emu_regs regs0 (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .addr     (addr),
      .write    (write),
      .wdata    (wdata),
      .ack      (ack),
      .rdata    (rdata),
      .ctrl     (ctrl_if.regs),
      .rx_empty (rx_empty),
      .rx_head  (rx_head),
      .rx_pop   (rx_pop),
      .tx_full  (tx_full),
      .tx_empty (tx_empty),
      .tx_push  (tx_push),
      .tx_data  (tx_data),
      .irq      (irq)
   );

   char_fifo rx_fifo (
      .clk   (clk),
      .rst   (rst),
      .clear (ctrl_if.rx_clear),
      .push  (in_valid),
      .wdata (in_char),
      .full  (rx_full),
      .pop   (rx_pop),
      .rdata (rx_head),
      .empty (rx_empty)
   );

   char_fifo tx_fifo (
      .clk   (clk),
      .rst   (rst),
      .clear (ctrl_if.tx_clear),
      .push  (tx_push),
      .wdata (tx_data),
      .full  (tx_full),
      .pop   (tx_pop),
      .rdata (tx_head),
      .empty (tx_empty)
   );

   tx_pace_timer timer0 (
      .clk     (clk),
      .rst     (rst),
      .start   (timer_start),
      .divisor (ctrl_if.divisor),
      .done    (timer_done)
   );

   tx_drain_fsm drain0 (
      .clk         (clk),
      .rst         (rst),
      .ctrl        (ctrl_if.tx),
      .tx_empty    (tx_empty),
      .tx_head     (tx_head),
      .tx_pop      (tx_pop),
      .timer_start (timer_start),
      .timer_done  (timer_done),
      .drop        (drop),
      .out_valid   (out_valid),
      .out_char    (out_char),
      .out_ready   (out_ready)
   );

endmodule

`default_nettype wire

//--- bench/tb_uart_emu.sv
// Self-checking testbench for the 16550 emulation front end, compiled from filelist.f as top
`default_nettype none

`include "uart_emu_config.svh"

module tb_uart_emu;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          FIFO_DEPTH     = 1 << `UART_FIFO_AW;
   localparam int          TIMEOUT_CYCLES = 20000;
   localparam logic [31:0] SEED           = 32'h4766df54;

   logic                    clk = 1'b0;
   logic                    rst;
   logic                    req;
   logic [`UART_ADDR_W-1:0] addr;
   logic                    write;
   logic [7:0]              wdata;
   logic                    ack;
   logic [7:0]              rdata;
   logic                    drop;
   logic                    out_valid;
   logic [7:0]              out_char;
   logic                    out_ready = 1'b0;
   logic                    in_valid;
   logic [7:0]              in_char;
   logic                    in_ready;
   logic                    irq;

   // Independent random streams for data, back-pressure and receive traffic
   logic [31:0] stim_seed  = SEED;
   logic [31:0] ready_seed = SEED ^ 32'h00ff00ff;
   logic [31:0] rx_seed    = SEED ^ 32'h5a5a5a5a;
   logic        ready_random = 1'b0;
   logic        ready_level  = 1'b0;

   // Reference model of the register state and both character paths
   logic [7:0]  rx_model [$];
   logic [7:0]  tx_model [$];
   int          rx_count = 0;
   int          tx_count = 0;
   logic        dlab_m;
   logic [1:0]  ier_m;
   logic [15:0] div_m;
   logic        irq_model;
   logic        hold_valid;
   logic [7:0]  hold_char;
   logic        prev_valid;
   int          last_rise = -1000000;
   int          gap_min;
   int          cycle = 0;

   uart_emu_top dut0 (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .addr      (addr),
      .write     (write),
      .wdata     (wdata),
      .ack       (ack),
      .rdata     (rdata),
      .drop      (drop),
      .out_valid (out_valid),
      .out_char  (out_char),
      .out_ready (out_ready),
      .in_valid  (in_valid),
      .in_char   (in_char),
      .in_ready  (in_ready),
      .irq       (irq)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic fail_check(input string name, input logic [31:0] got, input logic [31:0] exp);
      $display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, got, exp);
      stop_run();
   endtask

   task automatic fail_msg(input string why);
      $display("%s", why);
      stop_run();
   endtask

   // One bus access, held until ack is seen at a rising edge
   task automatic host_access(input logic [`UART_ADDR_W-1:0] a, input logic wr,
                              input logic [7:0] d, output logic [7:0] q);
      @(posedge clk);
      req   <= 1'b1;
      addr  <= a;
      write <= wr;
      wdata <= d;
      do @(posedge clk); while (!ack);
      q = rdata;
      req   <= 1'b0;
      write <= 1'b0;
   endtask

   task automatic bus_write(input logic [`UART_ADDR_W-1:0] a, input logic [7:0] d);
      logic [7:0] unused;
      host_access(a, 1'b1, d, unused);
   endtask

   task automatic bus_read(input logic [`UART_ADDR_W-1:0] a, output logic [7:0] q);
      host_access(a, 1'b0, 8'h00, q);
   endtask

   task automatic check_reg(input logic [`UART_ADDR_W-1:0] a, input logic [7:0] exp,
                            input string name);
      logic [7:0] d;
      bus_read(a, d);
      assert (d == exp) else fail_check(name, 32'(d), 32'(exp));
   endtask

   // rx_count still holds the pre-edge state when the read returns
   task automatic check_lsr_rx();
      logic [7:0] d;
      bus_read(uart_emu_pkg::LSR, d);
      assert (d[0] == (rx_count != 0)) else fail_check("LSR[0]", 32'(d[0]), 32'(rx_count != 0));
   endtask

   task automatic set_divisor(input logic [15:0] div);
      bus_write(uart_emu_pkg::LCR, 8'h80);
      bus_write(uart_emu_pkg::RBR_THR, div[7:0]);
      bus_write(uart_emu_pkg::IER, div[15:8]);
      check_reg(uart_emu_pkg::RBR_THR, div[7:0], "DLL");
      check_reg(uart_emu_pkg::IER, div[15:8], "DLM");
      bus_write(uart_emu_pkg::LCR, 8'h03);
   endtask

   // Offers random bytes with random gaps until n have been taken
   task automatic feed_rx(input int n);
      int sent;
      sent = 0;
      while (sent < n) begin
         @(posedge clk);
         if (in_valid && in_ready) begin
            sent++;
         end
         if (sent == n) begin
            in_valid <= 1'b0;
         end else if (!in_valid || in_ready) begin
            rx_seed = lcg_next(rx_seed);
            in_valid <= rx_seed[16];
            in_char  <= rx_seed[31:24];
         end
      end
   endtask

   task automatic wait_tx_drained();
      do @(posedge clk); while (tx_count != 0 || out_valid);
   endtask

   task automatic wait_tx_idle();
      logic [7:0] d;
      bus_read(uart_emu_pkg::LSR, d);
      while (!d[6]) begin
         bus_read(uart_emu_pkg::LSR, d);
      end
   endtask

   always @(posedge clk) begin
      ready_seed = lcg_next(ready_seed);
      if (ready_random) begin
         out_ready <= ready_seed[18];
      end else begin
         out_ready <= ready_level;
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles with the test still running", cycle);
         stop_run();
      end
   end

   assign irq_model = (ier_m[0] && rx_count != 0) || (ier_m[1] && tx_count == 0);

   always_comb begin
      gap_min = ((div_m == 16'd0) ? 1 : int'(div_m)) + 1;
   end

   always @(posedge clk) begin : monitor
      logic bus_done;
      logic rx_clr;
      logic tx_clr;
      bus_done = req && ack;
      rx_clr   = bus_done && write && addr == uart_emu_pkg::IIR_FCR && wdata[0] && wdata[1];
      tx_clr   = bus_done && write && addr == uart_emu_pkg::IIR_FCR && wdata[0] && wdata[2];
      if (rst) begin
         hold_valid <= 1'b0;
         prev_valid <= 1'b0;
         dlab_m     <= 1'b0;
         ier_m      <= 2'b00;
         div_m      <= 16'h0000;
      end else begin
         if (hold_valid) begin
            assert (out_valid) else fail_check("out_valid", 32'(out_valid), 32'd1);
            assert (out_char == hold_char) else fail_check("out_char", 32'(out_char), 32'(hold_char));
         end
         if (drop) begin
            assert (!out_valid) else fail_msg("out_valid was raised while drop was high");
         end
         if (out_valid && !prev_valid) begin
            assert (cycle - last_rise >= gap_min)
               else fail_check("out_valid rise spacing", cycle - last_rise, gap_min);
            last_rise <= cycle;
         end
         if (out_valid && out_ready) begin
            if (tx_model.size() == 0) begin
               fail_msg("a character was sent that was never written");
            end else begin
               assert (out_char == tx_model[0])
                  else fail_check("out_char", 32'(out_char), 32'(tx_model[0]));
               void'(tx_model.pop_front());
            end
         end
         if (tx_clr) begin
            tx_model.delete();
         end else if (bus_done && write && addr == uart_emu_pkg::RBR_THR && !dlab_m && !drop) begin
            tx_model.push_back(wdata);
         end
         if (rx_clr) begin
            rx_model.delete();
         end else begin
            if (bus_done && !write && addr == uart_emu_pkg::RBR_THR && !dlab_m) begin
               if (rx_model.size() == 0) begin
                  fail_msg("an RBR read was acknowledged with nothing received");
               end else begin
                  assert (rdata == rx_model[0])
                     else fail_check("rdata", 32'(rdata), 32'(rx_model[0]));
                  void'(rx_model.pop_front());
               end
            end
            if (in_valid && in_ready) begin
               rx_model.push_back(in_char);
            end
         end
         if (bus_done && write) begin
            if (addr == uart_emu_pkg::LCR) begin
               dlab_m <= wdata[7];
            end
            if (addr == uart_emu_pkg::IER && !dlab_m) begin
               ier_m <= wdata[1:0];
            end
            if (addr == uart_emu_pkg::RBR_THR && dlab_m) begin
               div_m[7:0] <= wdata;
            end
            if (addr == uart_emu_pkg::IER && dlab_m) begin
               div_m[15:8] <= wdata;
            end
         end
         // A queue clear may withdraw an offered character
         hold_valid <= out_valid && !out_ready && !tx_clr;
         hold_char  <= out_char;
         prev_valid <= out_valid;
      end
      rx_count <= rx_model.size();
      tx_count <= tx_model.size();
   end

   reset_outputs: assert property (@(posedge clk) rst |=> !ack && !out_valid && !irq && in_ready)
      else fail_msg("outputs were not at their reset values during reset");

   ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
      else fail_check("ack", 32'(ack), 32'd0);

   in_ready_level: assert property (@(posedge clk) disable iff (rst)
      in_ready == (rx_count < FIFO_DEPTH))
      else fail_check("in_ready", 32'(in_ready), 32'(rx_count < FIFO_DEPTH));

   irq_level: assert property (@(posedge clk) disable iff (rst) irq == irq_model)
      else fail_check("irq", 32'(irq), 32'(irq_model));

   initial begin : stimulus
      logic [7:0] d;
      int         i;
      rst      = 1'b1;
      req      = 1'b0;
      addr     = '0;
      write    = 1'b0;
      wdata    = 8'h00;
      drop     = 1'b0;
      in_valid = 1'b0;
      in_char  = 8'h00;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      assert (!ack && !out_valid && !irq && in_ready)
         else fail_msg("outputs were not idle after reset");

      // Register readback
      bus_write(uart_emu_pkg::LCR, 8'h1b);
      check_reg(uart_emu_pkg::LCR, 8'h1b, "LCR");
      bus_write(uart_emu_pkg::IER, 8'h05);
      check_reg(uart_emu_pkg::IER, 8'h05, "IER");
      bus_write(uart_emu_pkg::IER, 8'h00);
      set_divisor(16'h1234);
      check_reg(uart_emu_pkg::IIR_FCR, 8'h01, "IIR");
      check_reg(3'd7, 8'h00, "rdata at offset 7");

      // Transmit order and pacing under random back-pressure
      set_divisor(16'd5);
      ready_random <= 1'b1;
      for (i = 0; i < 24; i++) begin
         stim_seed = lcg_next(stim_seed);
         bus_write(uart_emu_pkg::RBR_THR, stim_seed[31:24]);
      end
      wait_tx_drained();
      ready_random <= 1'b0;

      // Receive path, first filled to the top then streamed
      feed_rx(FIFO_DEPTH);
      in_valid <= 1'b1;
      in_char  <= 8'h5a;
      repeat (4) @(posedge clk);
      assert (rx_count == FIFO_DEPTH) else fail_check("rx count", rx_count, FIFO_DEPTH);
      assert (!in_ready) else fail_check("in_ready", 32'(in_ready), 32'd0);
      in_valid <= 1'b0;
      check_lsr_rx();
      for (i = 0; i < FIFO_DEPTH; i++) begin
         bus_read(uart_emu_pkg::RBR_THR, d);
      end
      check_lsr_rx();
      fork
         feed_rx(12);
         begin
            for (i = 0; i < 12; i++) begin
               bus_read(uart_emu_pkg::RBR_THR, d);
               check_lsr_rx();
            end
         end
      join

      // Interrupt priority
      bus_write(uart_emu_pkg::IER, 8'h01);
      check_reg(uart_emu_pkg::IIR_FCR, 8'h01, "IIR");
      feed_rx(1);
      check_reg(uart_emu_pkg::IIR_FCR, 8'h04, "IIR");
      bus_write(uart_emu_pkg::IER, 8'h02);
      check_reg(uart_emu_pkg::IIR_FCR, 8'h02, "IIR");
      bus_write(uart_emu_pkg::IER, 8'h03);
      check_reg(uart_emu_pkg::IIR_FCR, 8'h04, "IIR");
      bus_read(uart_emu_pkg::RBR_THR, d);
      check_reg(uart_emu_pkg::IIR_FCR, 8'h02, "IIR");
      bus_write(uart_emu_pkg::IER, 8'h00);

      // Queue clears with both paths holding characters
      set_divisor(16'd40);
      ready_level <= 1'b0;
      for (i = 0; i < 4; i++) begin
         stim_seed = lcg_next(stim_seed);
         bus_write(uart_emu_pkg::RBR_THR, stim_seed[31:24]);
      end
      feed_rx(3);
      bus_write(uart_emu_pkg::IER, 8'h01);
      check_reg(uart_emu_pkg::LSR, 8'h01, "LSR");
      bus_write(uart_emu_pkg::IIR_FCR, 8'h07);
      check_reg(uart_emu_pkg::LSR, 8'h60, "LSR");
      check_reg(uart_emu_pkg::IIR_FCR, 8'hc1, "IIR");

      // Drop discards characters, then the path resumes
      set_divisor(16'd2);
      ready_level <= 1'b1;
      drop        <= 1'b1;
      for (i = 0; i < 5; i++) begin
         stim_seed = lcg_next(stim_seed);
         bus_write(uart_emu_pkg::RBR_THR, stim_seed[31:24]);
      end
      wait_tx_idle();
      drop <= 1'b0;
      for (i = 0; i < 2; i++) begin
         stim_seed = lcg_next(stim_seed);
         bus_write(uart_emu_pkg::RBR_THR, stim_seed[31:24]);
      end
      wait_tx_drained();

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/uart_emu_pkg.sv
verilog/uart_ctrl_if.sv
verilog/char_fifo.sv
verilog/tx_pace_timer.sv
verilog/tx_drain_fsm.sv
verilog/uart_emu_regs.sv
verilog/uart_emu_top.sv
bench/tb_uart_emu.sv

//--- Makefile
TOP := tb_uart_emu

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

obj_dir/V$(TOP): filelist.f verilog/*.sv verilog/*.svh bench/*.sv
	verilator --binary --assert --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
